// File: include/cache_config.svh
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// Global cache enable
// With 0 here every access is routed around the cache to the memory bus
`define CONFIG_CACHE 1

// Region value of cacheable RAM, taken from address bits 31 to 28
// Any other region is device space and always bypasses the cache
`define IO_CACHED 4'd0

`endif

// File: source/cache_pkg.sv
package cache_pkg;

	// A byte address or a 32-bit data word
	typedef logic [31:0] word_t;

	// Address fields from the top bit down: region, tag, line index, byte offset
	// The four widths add up to the width of word_t
	typedef logic [3:0]  addr_io_region;
	typedef logic [17:0] addr_tag;
	typedef logic [5:0]  addr_index;
	typedef logic [3:0]  addr_offset;

	// One cache line is 16 bytes, with one enable per byte
	typedef logic [127:0] line_t;
	typedef logic [15:0]  line_be;

	// All bytes of a line enabled, used for refills and write-throughs
	localparam line_be FULL_BE = '1;

	// One request on the line-wide memory bus
	// The address is always line aligned
	typedef struct packed {
		word_t  address;
		logic   read;
		logic   write;
		line_t  writedata;
		line_be byteenable;
	} mem_req_t;

	// Cache controller FSM
	typedef enum logic [1:0] {
		CTRL_IDLE,
		CTRL_LOOKUP,
		CTRL_REFILL,
		CTRL_WRITE_THROUGH
	} ctrl_state_e;

	// Memory bus arbiter FSM in the router
	typedef enum logic [1:0] {
		ROUTE_IDLE,
		ROUTE_CACHE,
		ROUTE_BYPASS
	} route_state_e;

	// Width of the line index needed to address a given number of lines
	// The line count must be a power of two no larger than 2**$bits(addr_index)
	function automatic int index_bits(int lines);
		return $clog2(lines);
	endfunction

endpackage

// File: source/cache_controller.sv
`include "cache_config.svh"

module cache_controller
	import cache_pkg::*;
#(
	parameter int NUM_LINES = 64
)(
	input  logic      clk,
	input  logic      rst_n,

	// Core side, already split and qualified as cacheable by the router
	input  addr_tag   tag,
	input  addr_index index,
	input  logic      read,
	input  logic      write,
	input  line_t     writedata,
	input  line_be    byteenable,
	output line_t     rdata,
	output logic      waitrequest,

	// Memory side, arbitrated by the router
	input  logic      mem_waitrequest,
	input  line_t     mem_readdata,
	output mem_req_t  mem_req
);

	// Direct-mapped, write-through, write-allocate cache
	// Lookups take one cycle, misses refill the whole line and every write is
	// sent to memory as a full merged line so memory never lags the cache

	localparam int IDX_W = index_bits(NUM_LINES);

	// Stored tag covers the full tag and index so that index bits above the
	// slot width still take part in the compare when NUM_LINES is small
	typedef logic [$bits(addr_tag) + $bits(addr_index) - 1:0] line_key_t;

	ctrl_state_e state;

	logic [NUM_LINES-1:0] valid;
	line_key_t            tags  [NUM_LINES];
	line_t                lines [NUM_LINES];

	logic [IDX_W-1:0] slot;
	line_key_t        key;
	logic             access;
	logic             hit;
	logic             done;
	logic             refill_ack;
	line_t            merged;

	assign slot   = index[IDX_W-1:0];
	assign key    = {tag, index};
	assign access = read || write;
	assign hit    = valid[slot] && tags[slot] == key;

	// The slot is read all the time, the router only forwards it for cached reads
	assign rdata = lines[slot];

	// The router holds this low for exactly one edge once memory accepts the refill
	assign refill_ack = state == CTRL_REFILL && !mem_waitrequest;

	// Enabled core bytes replace the stored ones, the rest of the line is kept
	always_comb begin
		for (int i = 0; i < $bits(line_be); i++) begin
			merged[8*i +: 8] = byteenable[i] ? writedata[8*i +: 8] : lines[slot][8*i +: 8];
		end
	end

	// A read finishes in LOOKUP once the line is present
	// A write only finishes when its write-through is accepted
	always_comb begin
		unique case (state)
			CTRL_LOOKUP:        done = hit && !write;
			CTRL_WRITE_THROUGH: done = !mem_waitrequest;
			default:            done = 1'b0;
		endcase
	end

	// Busy only while a core request is open and not yet answered
	assign waitrequest = access && !done;

	// Memory requests come straight from the state
	// Refills and write-throughs always move a whole line in region zero
	assign mem_req = '{
		address:    {addr_io_region'(`IO_CACHED), key, addr_offset'(0)},
		read:       state == CTRL_REFILL,
		write:      state == CTRL_WRITE_THROUGH,
		writedata:  lines[slot],
		byteenable: FULL_BE
	};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= CTRL_IDLE;
			valid <= '0;
		end else begin
			unique case (state)
				CTRL_IDLE:
					if (access)
						state <= CTRL_LOOKUP;

				CTRL_LOOKUP:
					// A miss fetches the line first, writes included
					if (!hit)
						state <= CTRL_REFILL;
					else if (write)
						state <= CTRL_WRITE_THROUGH;
					else
						state <= CTRL_IDLE;

				CTRL_REFILL:
					// Back to LOOKUP, which now hits and finishes the request
					if (refill_ack) begin
						valid[slot] <= 1'b1;
						state       <= CTRL_LOOKUP;
					end

				CTRL_WRITE_THROUGH:
					if (!mem_waitrequest)
						state <= CTRL_IDLE;
			endcase
		end
	end

	// Tag and data arrays
	always_ff @(posedge clk) begin
		if (refill_ack) begin
			tags[slot]  <= key;
			lines[slot] <= mem_readdata;
		end else if (state == CTRL_LOOKUP && hit && write) begin
			// Merged line lands here first and is then sent out unchanged
			lines[slot] <= merged;
		end
	end

endmodule

// File: source/cache_routing.sv
`include "cache_config.svh"

module cache_routing
	import cache_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,

	// Core port
	input  word_t      core_address,
	input  logic       core_read,
	input  logic       core_write,
	input  line_t      core_writedata,
	input  line_be     core_byteenable,
	output logic       core_waitrequest,
	output line_t      core_readdata,

	// Split address towards the cache controller
	output addr_tag    core_tag,
	output addr_index  core_index,
	output addr_offset core_offset,

	// Core side of the cache controller
	input  line_t      cache_rdata,
	input  logic       cache_waitrequest,
	output logic       cache_read,
	output logic       cache_write,

	// Memory side of the cache controller
	input  mem_req_t   cache_mem_req,
	output logic       cache_mem_waitrequest,

	// Memory bus
	input  logic       mem_waitrequest,
	input  line_t      mem_readdata,
	output mem_req_t   mem_req
);

	// Device registers must never be served from a stale cache copy, so only
	// region zero goes through the cache and the rest is sent to memory as is

	route_state_e state;

	addr_io_region io;
	word_t         core_address_line;
	logic          cached;
	logic          cache_pending;
	logic          bypass_req;
	logic          transition;

	// Registered memory request
	logic   mem_read_q;
	logic   mem_write_q;
	word_t  mem_address_q;
	line_t  mem_writedata_q;
	line_be mem_byteenable_q;

	assign {io, core_tag, core_index, core_offset} = core_address;

	// Bypass transfers are line wide, so the byte offset is dropped
	assign core_address_line = {io, core_tag, core_index, addr_offset'(0)};

	assign cached = io == `IO_CACHED && `CONFIG_CACHE != 0;

	assign cache_read  = core_read && cached;
	assign cache_write = core_write && cached;

	assign core_readdata = cached ? cache_rdata : mem_readdata;

	assign cache_pending = cache_mem_req.read || cache_mem_req.write;
	assign bypass_req    = !cached && (core_read || core_write);

	always_comb begin
		transition            = 1'b0;
		cache_mem_waitrequest = 1'b1;
		// Outside BYPASS an uncached request simply waits for the bus
		core_waitrequest      = cached ? cache_waitrequest : core_read || core_write;

		unique case (state)
			// The controller wins over the core when both want the bus
			ROUTE_IDLE:   transition = cache_pending || bypass_req;
			ROUTE_CACHE:  cache_mem_waitrequest = mem_waitrequest;
			ROUTE_BYPASS: core_waitrequest = mem_waitrequest;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state       <= ROUTE_IDLE;
			mem_read_q  <= 1'b0;
			mem_write_q <= 1'b0;
		end else begin
			unique case (state)
				ROUTE_IDLE:
					if (transition) begin
						state       <= cache_pending ? ROUTE_CACHE : ROUTE_BYPASS;
						mem_read_q  <= cache_pending ? cache_mem_req.read : core_read;
						mem_write_q <= cache_pending ? cache_mem_req.write : core_write;
					end

				ROUTE_CACHE, ROUTE_BYPASS:
					// Memory took the request on this edge
					if (!mem_waitrequest) begin
						state       <= ROUTE_IDLE;
						mem_read_q  <= 1'b0;
						mem_write_q <= 1'b0;
					end
			endcase
		end
	end

	// Payload of the granted request, held while memory stalls
	always_ff @(posedge clk) begin
		if (transition) begin
			mem_address_q    <= cache_pending ? cache_mem_req.address : core_address_line;
			mem_writedata_q  <= cache_pending ? cache_mem_req.writedata : core_writedata;
			mem_byteenable_q <= cache_pending ? cache_mem_req.byteenable : core_byteenable;
		end
	end

	assign mem_req = '{
		address:    mem_address_q,
		read:       mem_read_q,
		write:      mem_write_q,
		writedata:  mem_writedata_q,
		byteenable: mem_byteenable_q
	};

endmodule

// File: source/cache_subsys.sv
module cache_subsys
	import cache_pkg::*;
#(
	parameter int NUM_LINES = 64
)(
	input  logic     clk,
	input  logic     rst_n,

	// Core port
	input  word_t    core_address,
	input  logic     core_read,
	input  logic     core_write,
	input  line_t    core_writedata,
	input  line_be   core_byteenable,
	output logic     core_waitrequest,
	output line_t    core_readdata,

	// Memory port
	output mem_req_t mem_req,
	input  logic     mem_waitrequest,
	input  line_t    mem_readdata
);

	// Split core request towards the cache
	addr_tag   core_tag;
	addr_index core_index;
	logic      cache_read;
	logic      cache_write;

	// Cache answers to the core
	line_t     cache_rdata;
	logic      cache_waitrequest;

	// Cache traffic towards memory, through the router
	mem_req_t  cache_mem_req;
	logic      cache_mem_waitrequest;

	cache_routing u_routing (
		.clk                   (clk),
		.rst_n                 (rst_n),
		.core_address          (core_address),
		.core_read             (core_read),
		.core_write            (core_write),
		.core_writedata        (core_writedata),
		.core_byteenable       (core_byteenable),
		.core_waitrequest      (core_waitrequest),
		.core_readdata         (core_readdata),
		.core_tag              (core_tag),
		.core_index            (core_index),
		// Lines are whole, the cache never looks at the byte offset
		.core_offset           (),
		.cache_rdata           (cache_rdata),
		.cache_waitrequest     (cache_waitrequest),
		.cache_read            (cache_read),
		.cache_write           (cache_write),
		.cache_mem_req         (cache_mem_req),
		.cache_mem_waitrequest (cache_mem_waitrequest),
		.mem_waitrequest       (mem_waitrequest),
		.mem_readdata          (mem_readdata),
		.mem_req               (mem_req)
	);

	cache_controller #(
		.NUM_LINES (NUM_LINES)
	) u_ctrl (
		.clk             (clk),
		.rst_n           (rst_n),
		.tag             (core_tag),
		.index           (core_index),
		.read            (cache_read),
		.write           (cache_write),
		.writedata       (core_writedata),
		.byteenable      (core_byteenable),
		.rdata           (cache_rdata),
		.waitrequest     (cache_waitrequest),
		// Refill data comes straight off the bus, only the router grants it
		.mem_waitrequest (cache_mem_waitrequest),
		.mem_readdata    (mem_readdata),
		.mem_req         (cache_mem_req)
	);

endmodule

// File: bench/mem_model.sv
module mem_model
	import cache_pkg::*;
#(
	parameter logic [31:0] SEED = 32'd1729
)(
	input  logic     clk,
	input  logic     rst_n,
	input  mem_req_t req,
	output logic     waitrequest,
	output line_t    readdata
);

	timeunit 1ns;
	timeprecision 1ps;

	// Sparse line storage, keyed by the line-aligned address
	line_t       store [word_t];
	logic [31:0] lfsr;
	int          write_count;

	// Untouched lines read back a pattern built from every address bit
	function automatic line_t fill_line(word_t base);
		line_t l;
		for (int j = 0; j < 4; j++) begin
			l[32*j +: 32] = {base[31:4], 2'(j), 2'b00} ^ 32'hC3A5_5A3C;
		end
		return l;
	endfunction

	function automatic line_t line_at(word_t a);
		word_t base;
		base = {a[31:4], 4'h0};
		if (store.exists(base))
			return store[base];
		return fill_line(base);
	endfunction

	// Galois LFSR, x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(logic [31:0] s);
		return s[0] ? (s >> 1) ^ 32'h8020_0003 : s >> 1;
	endfunction

	// Readdata follows the address and any write to the store
	always @(req.address, write_count) begin
		readdata = line_at(req.address);
	end

	always @(posedge clk or negedge rst_n) begin
		line_t cur;
		if (!rst_n) begin
			lfsr        <= SEED;
			waitrequest <= 1'b1;
			write_count = 0;
		end else begin
			// One LFSR step for each waitrequest bit
			waitrequest <= lfsr[0];
			lfsr        <= lfsr_step(lfsr);
			if (req.write && !waitrequest) begin
				cur = line_at(req.address);
				for (int i = 0; i < 16; i++) begin
					if (req.byteenable[i])
						cur[8*i +: 8] = req.writedata[8*i +: 8];
				end
				store[{req.address[31:4], 4'h0}] = cur;
				write_count = write_count + 1;
			end
		end
	end

endmodule

// File: bench/tb_checker.sv
module tb_checker
	import cache_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  word_t    core_address,
	input  logic     core_read,
	input  logic     core_write,
	input  line_t    core_writedata,
	input  line_be   core_byteenable,
	input  logic     core_waitrequest,
	input  line_t    core_readdata,
	input  mem_req_t mem_req,
	input  logic     mem_waitrequest,
	input  int       exp_reads,
	input  int       exp_writes,
	output int       error_count,
	output int       cached_reads,
	output int       cached_writes,
	output int       device_reads,
	output int       device_writes
);

	timeunit 1ns;
	timeprecision 1ps;

	// Shadow byte memory, missing bytes come from the memory fill pattern
	logic [7:0] shadow [word_t];
	int         rd_since;
	int         wr_since;
	logic       seen_request;

	// Totals the traffic counters must reach, split by the region of each core access
	int         exp_cached_rd;
	int         exp_cached_wr;
	int         exp_device_rd;
	int         exp_device_wr;

	function automatic logic [7:0] shadow_byte(word_t a);
		logic [31:0] w;
		if (shadow.exists(a))
			return shadow[a];
		w = {a[31:4], a[3:2], 2'b00} ^ 32'hC3A5_5A3C;
		return w[8*a[1:0] +: 8];
	endfunction

	function automatic line_t shadow_line(word_t a);
		line_t l;
		for (int i = 0; i < 16; i++) begin
			l[8*i +: 8] = shadow_byte({a[31:4], 4'(i)});
		end
		return l;
	endfunction

	initial begin
		error_count   = 0;
		cached_reads  = 0;
		cached_writes = 0;
		device_reads  = 0;
		device_writes = 0;
		rd_since      = 0;
		wr_since      = 0;
		seen_request  = 1'b0;
		exp_cached_rd = 0;
		exp_cached_wr = 0;
		exp_device_rd = 0;
		exp_device_wr = 0;
	end

	// Values seen here are the ones from just before the edge
	always @(posedge clk) begin
		logic mem_acc;
		logic core_done;
		logic device;
		mem_acc   = (mem_req.read || mem_req.write) && !mem_waitrequest;
		core_done = (core_read || core_write) && !core_waitrequest;
		device    = mem_req.address[31:28] != 4'd0;
		// The bus stays quiet until the core asks for something
		if (!seen_request && (mem_req.read || mem_req.write)) begin
			$display("[FAIL] %0t ns: memory request before any core request", $time);
			error_count++;
		end
		if (rst_n && (core_read || core_write))
			seen_request = 1'b1;
		if (rst_n) begin
			if (core_done && core_read && core_readdata !== shadow_line(core_address)) begin
				$display("[FAIL] %0t ns: read %h got %h, expected %h", $time, core_address,
					core_readdata, shadow_line(core_address));
				error_count++;
			end
			// Merge first, a cached write-through is accepted on this same edge
			if (core_done && core_write) begin
				for (int i = 0; i < 16; i++) begin
					if (core_byteenable[i])
						shadow[{core_address[31:4], 4'(i)}] = core_writedata[8*i +: 8];
				end
			end
			if (mem_acc) begin
				if (mem_req.read)
					rd_since++;
				else
					wr_since++;
				if (device) begin
					if (mem_req.read)
						device_reads++;
					else
						device_writes++;
					if (mem_req.address !== {core_address[31:4], 4'h0} ||
						mem_req.byteenable !== core_byteenable ||
						(mem_req.write && mem_req.writedata !== core_writedata)) begin
						$display("[FAIL] %0t ns: device request %h be %h does not match core",
							$time, mem_req.address, mem_req.byteenable);
						error_count++;
					end
				end else begin
					if (mem_req.read)
						cached_reads++;
					else
						cached_writes++;
					// Refills and write-throughs both move the whole line of the core access
					if (mem_req.address !== {core_address[31:4], 4'h0} ||
						mem_req.byteenable !== FULL_BE) begin
						$display("[FAIL] %0t ns: cache request %h be %h is not the core line",
							$time, mem_req.address, mem_req.byteenable);
						error_count++;
					end
					if (mem_req.write && mem_req.writedata !== shadow_line(mem_req.address)) begin
						$display("[FAIL] %0t ns: write-through to %h carries %h, expected %h",
							$time, mem_req.address, mem_req.writedata,
							shadow_line(mem_req.address));
						error_count++;
					end
				end
			end
			// Memory traffic caused by the request that ends here
			if (core_done) begin
				if (core_address[31:28] == 4'd0) begin
					exp_cached_rd += exp_reads;
					exp_cached_wr += exp_writes;
				end else begin
					exp_device_rd += exp_reads;
					exp_device_wr += exp_writes;
				end
				if (rd_since != exp_reads || wr_since != exp_writes) begin
					$display("[FAIL] %0t ns: access %h made %0d reads %0d writes, expected %0d %0d",
						$time, core_address, rd_since, wr_since, exp_reads, exp_writes);
					error_count++;
				end
				if (cached_reads != exp_cached_rd || cached_writes != exp_cached_wr ||
					device_reads != exp_device_rd || device_writes != exp_device_wr) begin
					$display("[FAIL] %0t ns: access %h sent traffic to the wrong region",
						$time, core_address);
					error_count++;
				end
				rd_since = 0;
				wr_since = 0;
			end
		end
	end

endmodule

// File: bench/tb_cache_subsys.sv
module tb_cache_subsys
	import cache_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	typedef enum logic {
		OP_READ,
		OP_WRITE
	} op_e;

	// One core access with the memory traffic it must cause
	typedef struct packed {
		op_e        op;
		word_t      address;
		line_be     be;
		line_t      data;
		logic [1:0] exp_rd;
		logic [1:0] exp_wr;
	} row_t;

	localparam int NUM_ROWS = 16;
	localparam int MAX_WAIT = 200;

	logic     clk;
	logic     rst_n;
	word_t    core_address;
	logic     core_read;
	logic     core_write;
	line_t    core_writedata;
	line_be   core_byteenable;
	logic     core_waitrequest;
	line_t    core_readdata;
	mem_req_t mem_req;
	logic     mem_waitrequest;
	line_t    mem_readdata;
	int       exp_reads;
	int       exp_writes;
	int       error_count;
	int       cached_reads;
	int       cached_writes;
	int       device_reads;
	int       device_writes;
	int       timeouts;
	row_t     rows [NUM_ROWS];

	cache_subsys #(.NUM_LINES(64)) u_dut (.*);

	mem_model #(.SEED(32'd1729)) u_mem (
		.clk         (clk),
		.rst_n       (rst_n),
		.req         (mem_req),
		.waitrequest (mem_waitrequest),
		.readdata    (mem_readdata)
	);

	tb_checker u_chk (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Waits for the edge that accepts the current core request
	task automatic wait_accept(output logic ok);
		ok = 1'b0;
		for (int n = 0; n < MAX_WAIT && !ok; n++) begin
			@(posedge clk);
			if (!core_waitrequest)
				ok = 1'b1;
		end
	endtask

	initial begin
		logic ok;
		// Index 4 lines 0x040 and 0x440 share a slot, 0x3FF0 is the last slot
		rows[0]  = '{OP_READ,  32'h0000_0040, 16'hFFFF, 128'h0, 2'd1, 2'd0};
		rows[1]  = '{OP_READ,  32'h0000_0044, 16'hFFFF, 128'h0, 2'd0, 2'd0};
		rows[2]  = '{OP_WRITE, 32'h0000_0048, 16'h00F0, 128'h1111_2222_3333_4444_5555_6666_7777_8888,
			2'd0, 2'd1};
		rows[3]  = '{OP_READ,  32'h0000_0040, 16'hFFFF, 128'h0, 2'd0, 2'd0};
		rows[4]  = '{OP_READ,  32'h0000_0440, 16'hFFFF, 128'h0, 2'd1, 2'd0};
		rows[5]  = '{OP_READ,  32'h0000_0040, 16'hFFFF, 128'h0, 2'd1, 2'd0};
		rows[6]  = '{OP_WRITE, 32'h0000_0880, 16'h000F, 128'hDEAD_BEEF_0BAD_F00D_CAFE_D00D_FEED_FACE,
			2'd1, 2'd1};
		rows[7]  = '{OP_READ,  32'h0000_0888, 16'hFFFF, 128'h0, 2'd0, 2'd0};
		// Device space goes to memory every time
		rows[8]  = '{OP_READ,  32'h1000_0040, 16'hFFFF, 128'h0, 2'd1, 2'd0};
		rows[9]  = '{OP_WRITE, 32'h1000_0044, 16'h0F00, 128'hAAAA_BBBB_CCCC_DDDD_EEEE_FFFF_1234_5678,
			2'd0, 2'd1};
		rows[10] = '{OP_READ,  32'h1000_0040, 16'hFFFF, 128'h0, 2'd1, 2'd0};
		rows[11] = '{OP_READ,  32'h2000_0010, 16'h0003, 128'h0, 2'd1, 2'd0};
		rows[12] = '{OP_WRITE, 32'h0000_3FF0, 16'hFFFF, 128'h0102_0304_0506_0708_090A_0B0C_0D0E_0F10,
			2'd1, 2'd1};
		rows[13] = '{OP_READ,  32'h0000_3FF4, 16'hFFFF, 128'h0, 2'd0, 2'd0};
		rows[14] = '{OP_WRITE, 32'h0000_3FF0, 16'h8001, 128'h9900_0000_0000_0000_0000_0000_0000_0077,
			2'd0, 2'd1};
		rows[15] = '{OP_READ,  32'h0000_3FF0, 16'hFFFF, 128'h0, 2'd0, 2'd0};

		rst_n           = 1'b0;
		core_address    = '0;
		core_read       = 1'b0;
		core_write      = 1'b0;
		core_writedata  = '0;
		core_byteenable = '0;
		exp_reads       = 0;
		exp_writes      = 0;
		timeouts        = 0;

		repeat (5) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		// Idle cycles let the checker see a quiet bus
		repeat (3) @(negedge clk);

		for (int r = 0; r < NUM_ROWS && timeouts == 0; r++) begin
			core_address    = rows[r].address;
			core_read       = rows[r].op == OP_READ;
			core_write      = rows[r].op == OP_WRITE;
			core_writedata  = rows[r].data;
			core_byteenable = rows[r].be;
			exp_reads       = int'(rows[r].exp_rd);
			exp_writes      = int'(rows[r].exp_wr);
			wait_accept(ok);
			if (!ok) begin
				$display("Timeout: row %0d at address %h was never accepted", r,
					rows[r].address);
				timeouts++;
			end
			@(negedge clk);
			core_read  = 1'b0;
			core_write = 1'b0;
		end

		repeat (2) @(negedge clk);
		$display("errors %0d, timeouts %0d, cached rd %0d wr %0d, device rd %0d wr %0d",
			error_count, timeouts, cached_reads, cached_writes, device_reads, device_writes);
		if (error_count == 0 && timeouts == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// File: cache_subsys.f
+incdir+include
source/cache_pkg.sv
source/cache_controller.sv
source/cache_routing.sv
source/cache_subsys.sv
bench/mem_model.sv
bench/tb_checker.sv
bench/tb_cache_subsys.sv

// File: Makefile
# Verilator build for the cache subsystem
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
FILELIST  ?= cache_subsys.f
TB_TOP    ?= tb_cache_subsys
RTL_TOP   ?= cache_subsys
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= TEST RESULT: PASS
RTL_SRCS  ?= source/cache_pkg.sv source/cache_controller.sv \
             source/cache_routing.sv source/cache_subsys.sv

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Iinclude $(RTL_SRCS) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary --timing -f $(FILELIST) --top-module $(TB_TOP) \
		-Mdir $(BUILD_DIR) -o V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "Simulation did not pass" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
